// File: Bender.yml
package:
  name: i2c_slave

sources:
  - include_dirs:
      - design
    files:
      - design/i2c_slave_pkg.sv
      - design/i2c_line_sampler.sv
      - design/i2c_bit_counter.sv
      - design/i2c_transfer_fsm.sv
      - design/i2c_tx_driver.sv
      - design/reg_window_pointer.sv
      - design/i2c_slave_top.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/i2c_slave_tb.sv

// File: design/i2c_bit_counter.sv
/* frame position restarts only on START; a STOP leaves the count
   where it is, which is harmless since every transfer begins with START */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module i2c_bit_counter import i2c_slave_pkg::*; (
	input  logic       clock,
	input  logic       reset_n2,
	input  bus_event_t bus_ev,
	output rx_info_t   rx
);

	logic [3:0] bit_cnt; // 0..7 data bits, 8 is the ack slot
	i2c_byte_t  shift;

	always_ff @(posedge clock)
	begin
		if (bus_ev.scl_rise && bit_cnt < 4'(`I2C_BYTE_W))
			shift <= {shift[`I2C_BYTE_W-2:0], bus_ev.sda}; // msb first
	end

	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			bit_cnt <= '0;
			rx      <= '0;
		end
		else
		begin
			rx.byte_valid <= 1'b0;
			rx.ack_valid  <= 1'b0;
			if (bus_ev.start)
				bit_cnt <= '0;
			else if (bus_ev.scl_rise)
			begin
				if (bit_cnt == 4'(`I2C_BYTE_W))
				begin
					// ninth bit
					bit_cnt      <= '0;
					rx.ack_valid <= 1'b1;
					rx.ack_bit   <= bus_ev.sda;
				end
				else
				begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'(`I2C_BYTE_W - 1))
					begin
						rx.byte_valid <= 1'b1;
						rx.data       <= {shift[`I2C_BYTE_W-2:0], bus_ev.sda};
					end
				end
			end
		end
	end

endmodule

// File: design/i2c_line_sampler.sv
/* scl and sda_in are asynchronous; events lag the pins by 3 clocks.
   clock must run several times faster than SCL for START and STOP to be seen */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module i2c_line_sampler import i2c_slave_pkg::*; (
	input  logic       clock,
	input  logic       reset_n2,
	input  logic       scl,
	input  logic       sda_in,
	output bus_event_t bus_ev
);

	logic [`I2C_SYNC_STAGES-1:0] scl_sync; // [0] sees the pin first
	logic [`I2C_SYNC_STAGES-1:0] sda_sync;
	logic                        scl_s;
	logic                        sda_s;
	logic                        scl_h;    // last cycle's synced level
	logic                        sda_h;

	assign scl_s = scl_sync[`I2C_SYNC_STAGES-1];
	assign sda_s = sda_sync[`I2C_SYNC_STAGES-1];

	// --------------------------------------------------
	// synchronizers and one cycle of history
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			scl_sync <= '1; // idle bus is high
			sda_sync <= '1;
			scl_h    <= 1'b1;
			sda_h    <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[`I2C_SYNC_STAGES-2:0], scl};
			sda_sync <= {sda_sync[`I2C_SYNC_STAGES-2:0], sda_in};
			scl_h    <= scl_s;
			sda_h    <= sda_s;
		end
	end

	// --------------------------------------------------
	// registered edge and bus condition pulses
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
			bus_ev <= '0;
		else
		begin
			bus_ev.scl_rise <= scl_s & ~scl_h;
			bus_ev.scl_fall <= ~scl_s & scl_h;
			bus_ev.start    <= scl_s & scl_h & sda_h & ~sda_s; // sda falls, scl high
			bus_ev.stop     <= scl_s & scl_h & ~sda_h & sda_s; // sda rises, scl high
			bus_ev.sda      <= sda_s;
		end
	end

	// downstream blocks give stop priority, so both at once would be lost
	assert property (@(posedge clock) disable iff (!reset_n2)
		!(bus_ev.start && bus_ev.stop));

endmodule

// File: design/i2c_slave_consts.svh
/* fixed protocol widths and the register window bounds
   the window must stay inside one byte of register address */
`ifndef I2C_SLAVE_CONSTS_SVH
`define I2C_SLAVE_CONSTS_SVH

// byte and device address
`define I2C_BYTE_W      8
`define I2C_DEV_LOW_W   5
`define I2C_DEV_PREFIX  2'b11   // top two device address bits

// register window, both ends inclusive
`define I2C_WIN_LO      8'd32
`define I2C_WIN_HI      8'd55

// pin synchronizer depth
`define I2C_SYNC_STAGES 2

`endif

// File: design/i2c_slave_pkg.sv
/* types shared by the I2C slave blocks */
`include "i2c_slave_consts.svh"

package i2c_slave_pkg;

	typedef logic [`I2C_BYTE_W-1:0] i2c_byte_t;

	// one-cycle events seen on the sampled bus
	typedef struct packed {
		logic start;
		logic stop;
		logic scl_rise;
		logic scl_fall;
		logic sda;      // sampled level, not a pulse
	} bus_event_t;

	typedef struct packed {
		logic      byte_valid;
		i2c_byte_t data;
		logic      ack_valid;
		logic      ack_bit;    // 0 = ack from the other side
	} rx_info_t;

	typedef enum logic [3:0] {
		IDLE,
		DEV_ADDR,
		DEV_ACK,
		REG_ADDR,
		REG_ACK,
		WR_DATA,
		WR_ACK,
		RD_DATA,
		RD_ACK,
		HOLD
	} xfer_state_e;

	typedef enum logic [1:0] {
		TX_OFF,
		TX_ACK,
		TX_DATA
	} tx_mode_e;

endpackage

// File: design/i2c_slave_top.sv
/* I2C slave for a 24-byte register window at 32..55, storage is external.
   data_from_memory must be valid combinationally while mem_read is high */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module i2c_slave_top import i2c_slave_pkg::*; (
	input  logic                      clock,
	input  logic                      reset_n2,
	input  logic                      scl,
	input  logic                      sda_in,
	input  logic [`I2C_DEV_LOW_W-1:0] device_id,
	input  i2c_byte_t                 data_from_memory,
	output logic                      sda_out,
	output logic                      sda_en,
	output i2c_byte_t                 address,
	output i2c_byte_t                 data_to_memory,
	output logic                      mem_write,
	output logic                      mem_read
);

	bus_event_t bus_ev;
	rx_info_t   rx;
	tx_mode_e   tx_mode;
	logic       ptr_load;
	logic       ptr_inc;
	i2c_byte_t  reg_addr;

	i2c_line_sampler u_i2c_line_sampler (
		.clock    (clock),
		.reset_n2 (reset_n2),
		.scl      (scl),
		.sda_in   (sda_in),
		.bus_ev   (bus_ev)
	);

	i2c_bit_counter u_i2c_bit_counter (
		.clock    (clock),
		.reset_n2 (reset_n2),
		.bus_ev   (bus_ev),
		.rx       (rx)
	);

	i2c_transfer_fsm u_i2c_transfer_fsm (
		.clock          (clock),
		.reset_n2       (reset_n2),
		.bus_ev         (bus_ev),
		.rx             (rx),
		.device_id      (device_id),
		.address        (address),
		.tx_mode        (tx_mode),
		.ptr_load       (ptr_load),
		.ptr_inc        (ptr_inc),
		.reg_addr       (reg_addr),
		.mem_write      (mem_write),
		.mem_read       (mem_read),
		.data_to_memory (data_to_memory)
	);

	i2c_tx_driver u_i2c_tx_driver (
		.clock            (clock),
		.reset_n2         (reset_n2),
		.bus_ev           (bus_ev),
		.tx_mode          (tx_mode),
		.data_from_memory (data_from_memory),
		.sda_out          (sda_out),
		.sda_en           (sda_en)
	);

	reg_window_pointer u_reg_window_pointer (
		.clock    (clock),
		.reset_n2 (reset_n2),
		.ptr_load (ptr_load),
		.ptr_inc  (ptr_inc),
		.reg_addr (reg_addr),
		.address  (address)
	);

endmodule

// File: design/i2c_transfer_fsm.sv
/* one transfer at a time; register address bytes outside the window are NACKed
   and the rest of that transfer is ignored until the next START */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module i2c_transfer_fsm import i2c_slave_pkg::*; (
	input  logic                      clock,
	input  logic                      reset_n2,
	input  bus_event_t                bus_ev,
	input  rx_info_t                  rx,
	input  logic [`I2C_DEV_LOW_W-1:0] device_id,
	input  i2c_byte_t                 address,
	output tx_mode_e                  tx_mode,
	output logic                      ptr_load,
	output logic                      ptr_inc,
	output i2c_byte_t                 reg_addr,
	output logic                      mem_write,
	output logic                      mem_read,
	output i2c_byte_t                 data_to_memory
);

	xfer_state_e state;
	logic        rd_nwr;       // R/W bit of the device address
	logic        ack_seen;     // write ack sampled, wait for closing fall
	logic        byte_started; // read byte already fetched
	logic        dev_hit;
	logic        win_hit;

	assign dev_hit = rx.data[`I2C_BYTE_W-1:1] == {`I2C_DEV_PREFIX, device_id};
	assign win_hit = (rx.data >= `I2C_WIN_LO) && (rx.data <= `I2C_WIN_HI);

	// same fall on which the driver loads the byte
	assign mem_read = (state == RD_DATA) && bus_ev.scl_fall && !byte_started;

	always_ff @(posedge clock)
	begin
		if (rx.byte_valid && state == REG_ADDR)
			reg_addr <= rx.data;
		if (rx.byte_valid && state == WR_DATA)
			data_to_memory <= rx.data;
	end

	// --------------------------------------------------
	// main state machine
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			state        <= IDLE;
			tx_mode      <= TX_OFF;
			rd_nwr       <= 1'b0;
			ack_seen     <= 1'b0;
			byte_started <= 1'b0;
			ptr_load     <= 1'b0;
			ptr_inc      <= 1'b0;
			mem_write    <= 1'b0;
		end
		else
		begin
			ptr_load  <= 1'b0;
			ptr_inc   <= 1'b0;
			mem_write <= 1'b0;
			if (bus_ev.stop)
			begin
				state   <= IDLE;
				tx_mode <= TX_OFF;
			end
			else if (bus_ev.start)
			begin
				state        <= DEV_ADDR; // also a repeated start
				tx_mode      <= TX_OFF;
				ack_seen     <= 1'b0;
				byte_started <= 1'b0;
			end
			else
			begin
				case (state)
				IDLE, HOLD:
					tx_mode <= TX_OFF; // wait for start or stop
				DEV_ADDR:
					if (rx.byte_valid)
					begin
						rd_nwr  <= rx.data[0];
						tx_mode <= dev_hit ? TX_ACK : TX_OFF;
						state   <= dev_hit ? DEV_ACK : IDLE;
					end
				DEV_ACK:
					if (rx.ack_valid)
					begin
						tx_mode <= rd_nwr ? TX_DATA : TX_OFF;
						state   <= rd_nwr ? RD_DATA : REG_ADDR;
					end
				REG_ADDR:
					if (rx.byte_valid)
					begin
						ptr_load <= win_hit;
						tx_mode  <= win_hit ? TX_ACK : TX_OFF;
						state    <= win_hit ? REG_ACK : IDLE;
					end
				REG_ACK:
					if (rx.ack_valid)
					begin
						tx_mode <= TX_OFF;
						state   <= WR_DATA;
					end
				WR_DATA:
					if (rx.byte_valid)
					begin
						mem_write <= 1'b1;
						tx_mode   <= TX_ACK;
						ack_seen  <= 1'b0;
						state     <= WR_ACK;
					end
				WR_ACK:
					if (rx.ack_valid)
					begin
						ack_seen <= 1'b1;
						tx_mode  <= TX_OFF;
					end
					else if (ack_seen && bus_ev.scl_fall)
					begin
						ptr_inc  <= 1'b1; // ack slot closed
						ack_seen <= 1'b0;
						state    <= WR_DATA;
					end
				RD_DATA:
					if (rx.byte_valid)
					begin
						ptr_inc      <= 1'b1; // next fetch sees the new address
						byte_started <= 1'b0;
						state        <= RD_ACK;
					end
					else if (mem_read)
						byte_started <= 1'b1;
				RD_ACK:
					if (rx.ack_valid)
					begin
						tx_mode <= rx.ack_bit ? TX_OFF : TX_DATA;
						state   <= rx.ack_bit ? HOLD : RD_DATA; // master nack ends the read
					end
				default:
					state <= IDLE;
				endcase
			end
		end
	end

	// a memory write only ever follows a byte taken in WR_DATA
	assert property (@(posedge clock) disable iff (!reset_n2)
		mem_write |-> $past(state) == WR_DATA);

	// pointer picks up the loaded register address on the next cycle
	assert property (@(posedge clock) disable iff (!reset_n2)
		ptr_load |=> address == $past(reg_addr));

endmodule

// File: design/i2c_tx_driver.sv
/* open-drain style: sda_en high means pull, sda_out is the level driven.
   a NACK is just a released line */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module i2c_tx_driver import i2c_slave_pkg::*; (
	input  logic       clock,
	input  logic       reset_n2,
	input  bus_event_t bus_ev,
	input  tx_mode_e   tx_mode,
	input  i2c_byte_t  data_from_memory,
	output logic       sda_out,
	output logic       sda_en
);

	logic [3:0] bit_cnt; // data bits already on the line
	i2c_byte_t  shift;

	always_ff @(posedge clock)
	begin
		if (bus_ev.scl_fall && tx_mode == TX_DATA)
		begin
			if (bit_cnt == 4'd0)
				shift <= {data_from_memory[`I2C_BYTE_W-2:0], 1'b0};
			else
				shift <= {shift[`I2C_BYTE_W-2:0], 1'b0};
		end
	end

	// --------------------------------------------------
	// line control, changes only on scl falls
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			bit_cnt <= '0;
			sda_en  <= 1'b0;
			sda_out <= 1'b0;
		end
		else if (bus_ev.start)
		begin
			bit_cnt <= '0;
			sda_en  <= 1'b0; // let go for the new address
		end
		else if (bus_ev.scl_fall)
		begin
			case (tx_mode)
			TX_ACK:
			begin
				bit_cnt <= '0;
				sda_en  <= 1'b1;
				sda_out <= 1'b0;
			end
			TX_DATA:
				if (bit_cnt == 4'd0)
				begin
					bit_cnt <= 4'd1;
					sda_en  <= 1'b1;
					sda_out <= data_from_memory[`I2C_BYTE_W-1];
				end
				else if (bit_cnt == 4'(`I2C_BYTE_W))
				begin
					bit_cnt <= '0;
					sda_en  <= 1'b0; // master's ack slot
				end
				else
				begin
					bit_cnt <= bit_cnt + 4'd1;
					sda_out <= shift[`I2C_BYTE_W-1];
				end
			default:
			begin
				bit_cnt <= '0;
				sda_en  <= 1'b0;
			end
			endcase
		end
	end

	// never start pulling the line while a START is being seen
	assert property (@(posedge clock) disable iff (!reset_n2)
		$rose(sda_en) |-> !bus_ev.start);

endmodule

// File: design/reg_window_pointer.sv
/* address always stays inside the window; loads are only issued
   for addresses that already passed the window check */
`timescale 1ns/1ps
`include "i2c_slave_consts.svh"

module reg_window_pointer import i2c_slave_pkg::*; (
	input  logic      clock,
	input  logic      reset_n2,
	input  logic      ptr_load,
	input  logic      ptr_inc,
	input  i2c_byte_t reg_addr,
	output i2c_byte_t address
);

	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
			address <= `I2C_WIN_LO;
		else if (ptr_load) // load wins over increment
			address <= reg_addr;
		else if (ptr_inc)
		begin
			if (address == `I2C_WIN_HI)
				address <= `I2C_WIN_LO; // wrap to window base
			else
				address <= address + 8'd1;
		end
	end

	// relies on the FSM window check before every load
	assert property (@(posedge clock) disable iff (!reset_n2)
		(address >= `I2C_WIN_LO) && (address <= `I2C_WIN_HI));

endmodule

// File: i2c_slave_top.f
+incdir+design
+incdir+tests
design/i2c_slave_pkg.sv
design/i2c_line_sampler.sv
design/i2c_bit_counter.sv
design/i2c_transfer_fsm.sv
design/i2c_tx_driver.sv
design/reg_window_pointer.sv
design/i2c_slave_top.sv
tests/i2c_slave_tb.sv

// File: tests/i2c_master_tasks.svh
/* I2C master bus tasks, compare tasks and directed tests
   included inside the testbench module and driving its signals directly */
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// --------------------------------------------------
// failure reporting and compares

task automatic abort_run(input string why);
	error_count++;
	$display("%s", why);
	$display("Test FAILED");
	$fatal(1, "run stopped at the first error");
endtask

task automatic check_byte(input string name, input i2c_byte_t got, input i2c_byte_t expected);
	if (got !== expected)
	begin
		$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, expected);
		abort_run("byte result differs from the expected value");
	end
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
	if (got !== expected)
	begin
		$display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, expected);
		abort_run("bit result differs from the expected value");
	end
endtask

// register window 32..55, pointer wraps at the top
function automatic i2c_byte_t next_reg(input i2c_byte_t a);
	return (a == 8'd55) ? 8'd32 : a + 8'd1;
endfunction

function automatic i2c_byte_t device_byte(input logic rd);
	return {2'b11, device_id, rd};
endfunction

// --------------------------------------------------
// master bus tasks, inputs change 1 ns after a rising clock

task automatic wait_clocks(input int n);
	repeat (n) @(posedge clock);
	#1;
endtask

// one SCL period, sda set early in the low half, line sampled late in the high half
task automatic clock_bit(input logic bit_out, output logic bit_seen);
	wait_clocks(4);
	master_sda = bit_out;
	wait_clocks(half_clocks - 4);
	scl = 1'b1;
	wait_clocks(half_clocks);
	bit_seen = sda_line;
	scl = 1'b0;
endtask

task automatic start_cond();
	wait_clocks(4);
	master_sda = 1'b1; // also works as a repeated start
	wait_clocks(half_clocks - 4);
	scl = 1'b1;
	wait_clocks(half_clocks);
	master_sda = 1'b0; // falls while scl high
	wait_clocks(half_clocks);
	scl = 1'b0;
endtask

task automatic stop_cond();
	wait_clocks(4);
	master_sda = 1'b0;
	wait_clocks(half_clocks - 4);
	scl = 1'b1;
	wait_clocks(half_clocks);
	master_sda = 1'b1; // rises while scl high
	wait_clocks(half_clocks);
endtask

task automatic send_byte(input i2c_byte_t b, output logic ack);
	logic seen;
	for (int i = 7; i >= 0; i--)
		clock_bit(b[i], seen);
	clock_bit(1'b1, ack); // line released for the slave
endtask

task automatic read_byte(input logic ack_out, output i2c_byte_t b);
	logic seen;
	for (int i = 7; i >= 0; i--)
	begin
		clock_bit(1'b1, seen);
		b[i] = seen;
	end
	clock_bit(ack_out, seen);
endtask

// --------------------------------------------------
// directed tests

task automatic test_reset_state();
	check_bit("sda_en", sda_en, 1'b0);
	check_bit("mem_write", mem_write, 1'b0);
	check_bit("mem_read", mem_read, 1'b0);
	check_byte("address", address, 8'd32);
endtask

task automatic test_wrong_device();
	logic ack;
	wr_addr_q.delete();
	wr_data_q.delete();
	start_cond();
	send_byte(device_byte(1'b0) ^ 8'h02, ack); // flips device_id bit 0
	check_bit("device ack", ack, 1'b1);
	send_byte(8'd40, ack);
	check_bit("second byte ack", ack, 1'b1);
	stop_cond();
	check_bit("mem_write seen", wr_addr_q.size() != 0, 1'b0);
endtask

task automatic write_and_check(input i2c_byte_t first_reg, input string label);
	i2c_byte_t data[3];
	i2c_byte_t exp_addr;
	logic      ack;
	for (int i = 0; i < 3; i++)
		data[i] = i2c_byte_t'($urandom);
	wr_addr_q.delete();
	wr_data_q.delete();
	start_cond();
	send_byte(device_byte(1'b0), ack);
	check_bit("device ack", ack, 1'b0);
	send_byte(first_reg, ack);
	check_bit("register ack", ack, 1'b0);
	for (int i = 0; i < 3; i++)
	begin
		send_byte(data[i], ack);
		check_bit("data ack", ack, 1'b0);
	end
	stop_cond();
	if (wr_addr_q.size() != 3)
		abort_run($sformatf("%s: expected 3 memory writes, saw %0d", label, wr_addr_q.size()));
	exp_addr = first_reg;
	for (int i = 0; i < 3; i++)
	begin
		check_byte("address", wr_addr_q[i], exp_addr);
		check_byte("data_to_memory", wr_data_q[i], data[i]);
		exp_addr = next_reg(exp_addr);
	end
endtask

task automatic test_reg_outside_window();
	logic ack;
	wr_addr_q.delete();
	wr_data_q.delete();
	start_cond();
	send_byte(device_byte(1'b0), ack);
	check_bit("device ack", ack, 1'b0);
	send_byte(8'd60, ack);
	check_bit("register ack", ack, 1'b1); // outside 32..55
	send_byte(8'h5A, ack);
	check_bit("data ack", ack, 1'b1);
	stop_cond();
	check_bit("mem_write seen", wr_addr_q.size() != 0, 1'b0);
endtask

task automatic test_read_after_pointer_set();
	i2c_byte_t got;
	i2c_byte_t exp_addr;
	logic      ack;
	int        rd_before;
	rd_before = rd_count;
	start_cond();
	send_byte(device_byte(1'b0), ack);
	check_bit("device ack", ack, 1'b0);
	send_byte(8'd50, ack);
	check_bit("register ack", ack, 1'b0);
	start_cond();
	send_byte(device_byte(1'b1), ack);
	check_bit("device ack", ack, 1'b0);
	exp_addr = 8'd50;
	for (int i = 0; i < 3; i++)
	begin
		read_byte(i == 2, got); // nack on the last byte
		check_byte("read data", got, exp_addr ^ 8'hA5);
		exp_addr = next_reg(exp_addr);
	end
	stop_cond();
	check_bit("sda_en", sda_en, 1'b0);
	if (rd_count - rd_before != 3)
		abort_run($sformatf("expected 3 memory reads, saw %0d", rd_count - rd_before));
endtask

`endif

// File: tests/i2c_slave_tb.sv
/* testbench for the I2C slave, device_id fixed at 5'h0A
   memory model answers reads with address xor A5 */
`timescale 1ns/1ps

module i2c_slave_tb import i2c_slave_pkg::*; ();

	localparam int half_clocks = 12;
	// bus bits per test, start and stop about 1.5 bits each
	localparam int bus_bits = 21 + 48 + 48 + 30 + 59;
	localparam int timeout_cycles = bus_bits * 2 * half_clocks + 4000;

	logic       clock;
	logic       reset_n2;
	logic       scl;
	logic       master_sda;
	logic       sda_line;   // shared wire as both ends see it
	logic [4:0] device_id;
	i2c_byte_t  data_from_memory;
	logic       sda_out;
	logic       sda_en;
	i2c_byte_t  address;
	i2c_byte_t  data_to_memory;
	logic       mem_write;
	logic       mem_read;
	i2c_byte_t  wr_addr_q[$];
	i2c_byte_t  wr_data_q[$];
	int         rd_count = 0;
	int         cycle_count = 0;
	int         error_count = 0;
	int         seed_ret;

	`include "i2c_master_tasks.svh"

	assign sda_line = sda_en ? sda_out : master_sda;

	i2c_slave_top u_i2c_slave_top (
		.clock            (clock),
		.reset_n2         (reset_n2),
		.scl              (scl),
		.sda_in           (sda_line),
		.device_id        (device_id),
		.data_from_memory (data_from_memory),
		.sda_out          (sda_out),
		.sda_en           (sda_en),
		.address          (address),
		.data_to_memory   (data_to_memory),
		.mem_write        (mem_write),
		.mem_read         (mem_read)
	);

	initial
		clock = 1'b0;
	always #4 clock = ~clock; // 8 ns period

	// --------------------------------------------------
	// memory model, sampled mid-cycle
	assign data_from_memory = address ^ 8'hA5;

	always @(negedge clock)
	begin
		if (mem_write)
		begin
			wr_addr_q.push_back(address);
			wr_data_q.push_back(data_to_memory);
		end
		if (mem_read)
			rd_count++;
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
			abort_run($sformatf("timeout, tests not done after %0d cycles", timeout_cycles));
	end

	// --------------------------------------------------
	// test sequence
	initial
	begin
		seed_ret   = $urandom(32'h9c820378);
		reset_n2   = 1'b0;
		scl        = 1'b1; // idle bus
		master_sda = 1'b1;
		device_id  = 5'h0A;
		repeat (16) @(posedge clock);
		#1;
		reset_n2 = 1'b1;
		wait_clocks(4);

		test_reset_state();
		test_wrong_device();
		write_and_check(8'd40, "write at 40");
		write_and_check(8'd54, "write across the wrap");
		test_reg_outside_window();
		test_read_after_pointer_set();
		wait_clocks(half_clocks);

		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
